// File: hw/hostPkg.sv
package hostPkg;

    // Host word layout
    localparam int WordWidth = 32;

    typedef logic [WordWidth-1:0] hostWord_t;

    // Opcode in the top two bits of a host word
    typedef enum logic [1:0] {
        opCommand = 2'b00,
        opData    = 2'b01,
        opFill    = 2'b10,
        opControl = 2'b11
    } hostOp_e;

    //----------------------------------------
    // Field positions
    //----------------------------------------
    localparam int OpMsb    = 31;
    localparam int OpLsb    = 30;

    // Fill run length minus one
    localparam int CountMsb = 29;
    localparam int CountLsb = 16;

endpackage

// File: hw/lcdPkg.sv
package lcdPkg;

    // Parallel bus width of the ILI9341 in 16-bit mode
    localparam int DataWidth = 16;

    // What the writer does with an entry
    typedef enum logic [1:0] {
        kindCommand = 2'b00,
        kindData    = 2'b01,
        kindControl = 2'b10
    } lcdKind_e;

    //----------------------------------------
    // Queue entry between decoder and writer
    //----------------------------------------
    typedef struct packed {
        lcdKind_e               kind;
        logic [DataWidth-1:0]   data;
    } lcdEntry_t;

    // Control entries use data bits 1:0
    // bit 0 is backlight, bit 1 is the panel reset pin

    //----------------------------------------
    // Default write strobe timing in clocks
    //----------------------------------------
    localparam int DefaultWrLow  = 2;
    localparam int DefaultWrHigh = 2;

endpackage

// File: hw/lcdBus.sv
`timescale 1ns/1ps

interface lcdBus;

    // Panel pins, all active as on the ILI9341 8080 interface
    logic                           cs;
    logic                           rs;
    logic                           wr;
    logic [lcdPkg::DataWidth-1:0]   data;
    logic                           rst;
    logic                           backlight;

    // Writer side drives every pin
    modport writer (
        output cs, rs, wr, data, rst, backlight
    );

    // Top level reads them out to the pads
    modport panel (
        input cs, rs, wr, data, rst, backlight
    );

endinterface

// File: hw/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
    parameter int  Depth   = 4,
    parameter type Payload = logic [7:0]
) (
    input  logic    clk,
    input  logic    RSTn,
    input  logic    push,
    input  Payload  pushData,
    input  logic    pop,
    output logic    headValid,
    output Payload  headData,
    output logic    credit
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    Payload                 mem [Depth];
    logic [PtrWidth-1:0]    rdPtr;
    logic [PtrWidth-1:0]    wrPtr;
    logic [CountWidth-1:0]  count;
    logic                   doPop;

    // Upstream credits keep push away from a full buffer
    assign doPop     = pop && headValid;
    assign headValid = (count != '0);
    assign headData  = mem[rdPtr];

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //----------------------------------------
    // Storage
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    //----------------------------------------
    // Pointers, occupancy and credit return
    //----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            rdPtr  <= '0;
            wrPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One pulse per freed slot
            credit <= doPop;
        end
    end

endmodule

// File: hw/wordDecoder.sv
`timescale 1ns/1ps

module wordDecoder #(
    parameter int EntryDepth = 4
) (
    input  logic                clk,
    input  logic                RSTn,
    input  logic                wordValid,
    input  hostPkg::hostWord_t  wordData,
    output logic                wordPop,
    output logic                entryValid,
    output lcdPkg::lcdEntry_t   entryData,
    input  logic                entryCredit
);

    localparam int CountWidth  = hostPkg::CountMsb - hostPkg::CountLsb + 1;
    localparam int CreditWidth = $clog2(EntryDepth + 1);

    hostPkg::hostOp_e           op;
    logic [CountWidth-1:0]      fillCount;
    logic [CountWidth-1:0]      runCount;
    logic [CreditWidth-1:0]     credits;
    logic                       lastEntry;

    //----------------------------------------
    // Field extraction
    //----------------------------------------
    assign op        = hostPkg::hostOp_e'(wordData[hostPkg::OpMsb:hostPkg::OpLsb]);
    assign fillCount = wordData[hostPkg::CountMsb:hostPkg::CountLsb];

    // Fill repeats until the run reaches its count, other words give one entry
    assign lastEntry = (op != hostPkg::opFill) || (runCount == fillCount);

    // Push only with a free slot downstream
    assign entryValid = wordValid && (credits != '0);
    assign wordPop    = entryValid && lastEntry;

    //----------------------------------------
    // Opcode to entry mapping
    //----------------------------------------
    always_comb begin
        entryData.data = wordData[lcdPkg::DataWidth-1:0];
        case (op)
            hostPkg::opCommand: begin
                entryData.kind = lcdPkg::kindCommand;
            end
            hostPkg::opData,
            hostPkg::opFill: begin
                entryData.kind = lcdPkg::kindData;
            end
            default: begin
                // Backlight and reset level only
                entryData.kind = lcdPkg::kindControl;
                entryData.data = {{(lcdPkg::DataWidth - 2){1'b0}}, wordData[1:0]};
            end
        endcase
    end

    //----------------------------------------
    // Run counter for fill words
    //----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            runCount <= '0;
        end else if (entryValid) begin
            if (lastEntry) begin
                runCount <= '0;
            end else begin
                runCount <= runCount + 1'b1;
            end
        end
    end

    //----------------------------------------
    // Entry FIFO credits
    //----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            credits <= CreditWidth'(EntryDepth);
        end else begin
            case ({entryValid, entryCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: hw/lcdWriter.sv
`timescale 1ns/1ps

module lcdWriter #(
    parameter int WrLowCycles  = lcdPkg::DefaultWrLow,
    parameter int WrHighCycles = lcdPkg::DefaultWrHigh
) (
    input  logic                clk,
    input  logic                RSTn,
    input  logic                headValid,
    input  lcdPkg::lcdEntry_t   headData,
    output logic                pop,
    lcdBus.writer               bus
);

    localparam int PhaseMax   = (WrLowCycles > WrHighCycles) ? WrLowCycles : WrHighCycles;
    localparam int PhaseWidth = $clog2(PhaseMax + 1);

    typedef enum logic [1:0] {
        stIdle,
        stLow,
        stHigh
    } state_e;

    state_e                 state;
    logic [PhaseWidth-1:0]  phase;
    logic                   takeSlot;
    logic                   isControl;

    // Next entry is taken in idle or on the last high cycle, so writes run back to back
    assign takeSlot  = (state == stIdle) ||
                       ((state == stHigh) && (phase == PhaseWidth'(WrHighCycles - 1)));
    assign pop       = takeSlot && headValid;
    assign isControl = (headData.kind == lcdPkg::kindControl);

    //----------------------------------------
    // Bus sequencer
    //----------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state         <= stIdle;
            phase         <= '0;
            bus.cs        <= 1'b1;
            bus.wr        <= 1'b1;
            bus.rs        <= 1'b0;
            bus.data      <= '0;
            bus.rst       <= 1'b0;
            bus.backlight <= 1'b0;
        end else if (takeSlot) begin
            phase <= '0;
            if (pop && !isControl) begin
                // A write starts and rs and data launch with the wr fall
                state    <= stLow;
                bus.cs   <= 1'b0;
                bus.wr   <= 1'b0;
                bus.rs   <= (headData.kind == lcdPkg::kindData);
                bus.data <= headData.data;
            end else begin
                state  <= stIdle;
                bus.cs <= 1'b1;
                if (pop) begin
                    bus.backlight <= headData.data[0];
                    bus.rst       <= headData.data[1];
                end
            end
        end else if (state == stLow) begin
            if (phase == PhaseWidth'(WrLowCycles - 1)) begin
                // Rising edge latches the panel data
                state  <= stHigh;
                phase  <= '0;
                bus.wr <= 1'b1;
            end else begin
                phase <= phase + 1'b1;
            end
        end else begin
            phase <= phase + 1'b1;
        end
    end

endmodule

// File: hw/lcdPanelTop.sv
`timescale 1ns/1ps

module lcdPanelTop #(
    parameter int WordDepth    = 4,
    parameter int EntryDepth   = 4,
    parameter int WrLowCycles  = lcdPkg::DefaultWrLow,
    parameter int WrHighCycles = lcdPkg::DefaultWrHigh
) (
    input  logic                            clk,
    input  logic                            RSTn,

    // Host side
    input  logic                            wordValid,
    input  hostPkg::hostWord_t              wordData,
    output logic                            wordCredit,

    // ILI9341 pins
    output logic                            lcdCs,
    output logic                            lcdRs,
    output logic                            lcdWr,
    output logic                            lcdRd,
    output logic                            lcdRst,
    output logic [lcdPkg::DataWidth-1:0]    lcdData,
    output logic                            lcdBacklight
);

    //----------------------------------------
    // Stage links
    //----------------------------------------
    logic                   wordHeadValid;
    hostPkg::hostWord_t     wordHeadData;
    logic                   wordPop;

    logic                   entryValid;
    lcdPkg::lcdEntry_t      entryData;
    logic                   entryCredit;

    logic                   entryHeadValid;
    lcdPkg::lcdEntry_t      entryHeadData;
    logic                   entryPop;

    lcdBus panelBus ();

    creditFifo #(
        .Depth      (WordDepth),
        .Payload    (hostPkg::hostWord_t)
    ) wordFifo (
        .clk        (clk),
        .RSTn       (RSTn),
        .push       (wordValid),
        .pushData   (wordData),
        .pop        (wordPop),
        .headValid  (wordHeadValid),
        .headData   (wordHeadData),
        .credit     (wordCredit)
    );

    wordDecoder #(
        .EntryDepth (EntryDepth)
    ) decoder (
        .clk         (clk),
        .RSTn        (RSTn),
        .wordValid   (wordHeadValid),
        .wordData    (wordHeadData),
        .wordPop     (wordPop),
        .entryValid  (entryValid),
        .entryData   (entryData),
        .entryCredit (entryCredit)
    );

    creditFifo #(
        .Depth      (EntryDepth),
        .Payload    (lcdPkg::lcdEntry_t)
    ) entryFifo (
        .clk        (clk),
        .RSTn       (RSTn),
        .push       (entryValid),
        .pushData   (entryData),
        .pop        (entryPop),
        .headValid  (entryHeadValid),
        .headData   (entryHeadData),
        .credit     (entryCredit)
    );

    lcdWriter #(
        .WrLowCycles  (WrLowCycles),
        .WrHighCycles (WrHighCycles)
    ) writer (
        .clk        (clk),
        .RSTn       (RSTn),
        .headValid  (entryHeadValid),
        .headData   (entryHeadData),
        .pop        (entryPop),
        .bus        (panelBus.writer)
    );

    // Pad outputs with the read strobe held inactive
    assign lcdCs        = panelBus.panel.cs;
    assign lcdRs        = panelBus.panel.rs;
    assign lcdWr        = panelBus.panel.wr;
    assign lcdRd        = 1'b1;
    assign lcdRst       = panelBus.panel.rst;
    assign lcdData      = panelBus.panel.data;
    assign lcdBacklight = panelBus.panel.backlight;

endmodule

// File: sim/tbLcdPanel.sv
`timescale 1ns/1ps

module tbLcdPanel;

    localparam int WordDepth     = 4;
    localparam int EntryDepth    = 3;
    localparam int WrLowCycles   = 3;
    localparam int WrHighCycles  = 2;
    localparam int TimeoutCycles = 4000;
    // Long enough for queued control words to finish after the last write
    localparam int QuietCycles   = WordDepth + EntryDepth + WrLowCycles + WrHighCycles + 8;
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;

    logic                           clk;
    logic                           RSTn;
    logic                           wordValid;
    hostPkg::hostWord_t             wordData;
    logic                           wordCredit;
    logic                           lcdCs;
    logic                           lcdRs;
    logic                           lcdWr;
    logic                           lcdRd;
    logic                           lcdRst;
    logic [lcdPkg::DataWidth-1:0]   lcdData;
    logic                           lcdBacklight;

    // Expected stream with control in bit 17, rs in bit 16 and data in 15:0
    logic [17:0]    expQ [$];
    logic [1:0]     finalCtrl;
    logic [31:0]    lfsr;
    logic           prevWr;
    logic [1:0]     prevCtrl;
    int             hostCredits;
    int             pendingWrites;
    int             lowLen;
    int             errors;
    int             writesChecked;
    int             testsDone;

    lcdPanelTop #(
        .WordDepth    (WordDepth),
        .EntryDepth   (EntryDepth),
        .WrLowCycles  (WrLowCycles),
        .WrHighCycles (WrHighCycles)
    ) uut (
        .clk          (clk),
        .RSTn         (RSTn),
        .wordValid    (wordValid),
        .wordData     (wordData),
        .wordCredit   (wordCredit),
        .lcdCs        (lcdCs),
        .lcdRs        (lcdRs),
        .lcdWr        (lcdWr),
        .lcdRd        (lcdRd),
        .lcdRst       (lcdRst),
        .lcdData      (lcdData),
        .lcdBacklight (lcdBacklight)
    );

    always #20 clk = ~clk;

    // Host side credit counter
    always @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            hostCredits <= WordDepth;
        end else begin
            hostCredits <= hostCredits - int'(wordValid) + int'(wordCredit);
        end
    end

    // Sampled cycles of wr low
    always @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            lowLen <= 0;
        end else begin
            lowLen <= lcdWr ? 0 : lowLen + 1;
        end
    end

    //----------------------------------------
    // Bus timing assertions
    //----------------------------------------
    resetState: assert property (@(posedge clk) !RSTn |->
        (lcdCs && lcdWr && lcdRd && !lcdRst && !lcdBacklight && lcdData == '0 && !wordCredit))
        else begin
            $display("FAIL %0t: panel pins left the reset state during reset", $time);
            errors++;
        end

    csDuringWrite: assert property (@(posedge clk) disable iff (!RSTn) !lcdWr |-> !lcdCs)
        else begin
            $display("FAIL %0t: lcdCs high while lcdWr is low", $time);
            errors++;
        end

    strobeLength: assert property (@(posedge clk) disable iff (!RSTn)
        $rose(lcdWr) |-> (lowLen == WrLowCycles))
        else begin
            $display("FAIL %0t: lcdWr low for %0d cycles, expected %0d", $time, lowLen,
                     WrLowCycles);
            errors++;
        end

    // Held through the low phase and the cycle after the rise
    dataStable: assert property (@(posedge clk) disable iff (!RSTn)
        !$past(lcdWr) |-> ($stable(lcdRs) && $stable(lcdData)))
        else begin
            $display("FAIL %0t: lcdRs or lcdData moved during a write", $time);
            errors++;
        end

    controlIdle: assert property (@(posedge clk) disable iff (!RSTn)
        (!$stable(lcdBacklight) || !$stable(lcdRst)) |-> lcdCs)
        else begin
            $display("FAIL %0t: control levels changed with lcdCs low", $time);
            errors++;
        end

    // Extra credit pulses from the DUT push the count above the FIFO depth
    hostCredit: assert property (@(posedge clk) disable iff (!RSTn)
        (hostCredits <= WordDepth) && (!wordValid || hostCredits != 0))
        else begin
            $display("Host credit count %0d at %0t broke the credit rule", hostCredits,
                     $time);
            errors++;
        end

    //----------------------------------------
    // Panel-side monitor
    //----------------------------------------
    always @(posedge clk) begin
        logic [17:0] entry;
        logic        sawCtrl;
        logic [1:0]  ctrlLevel;
        sawCtrl   = 1'b0;
        ctrlLevel = 2'b00;
        if (!RSTn) begin
            prevWr   = 1'b1;
            prevCtrl = 2'b00;
        end else begin
            if (prevWr && !lcdWr) begin
                // Controls queued ahead of this write must already be applied
                while (expQ.size() > 0 && expQ[0][17]) begin
                    entry     = expQ.pop_front();
                    sawCtrl   = 1'b1;
                    ctrlLevel = entry[1:0];
                end
                if (sawCtrl) begin
                    controlOrder: assert ({lcdRst, lcdBacklight} == ctrlLevel) else begin
                        $display("FAIL %0t: control levels %b before write, expected %b",
                                 $time, {lcdRst, lcdBacklight}, ctrlLevel);
                        errors++;
                    end
                end
                extraWrite: assert (expQ.size() != 0) else begin
                    $display("Unexpected write at %0t with nothing left to write", $time);
                    errors++;
                end
                if (expQ.size() != 0) begin
                    entry = expQ.pop_front();
                    writesChecked++;
                    pendingWrites--;
                    writeValue: assert (lcdRs == entry[16] && lcdData == entry[15:0]) else begin
                        $display("FAIL %0t: write rs=%b data=%h, expected rs=%b data=%h",
                                 $time, lcdRs, lcdData, entry[16], entry[15:0]);
                        errors++;
                    end
                end
            end
            if ({lcdRst, lcdBacklight} != prevCtrl) begin
                controlEarly: assert (expQ.size() > 0 && expQ[0][17]) else begin
                    $display("Control levels changed at %0t before earlier writes ended",
                             $time);
                    errors++;
                end
            end
            prevWr   = lcdWr;
            prevCtrl = {lcdRst, lcdBacklight};
        end
    end

    //----------------------------------------
    // Stimulus helpers
    //----------------------------------------
    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic hostPkg::hostWord_t randomWord();
        hostPkg::hostWord_t word;
        logic [31:0]        bits;
        word        = '0;
        bits        = randBits(2);
        word[31:30] = bits[1:0];
        // Fill count kept below 8
        bits        = randBits(3);
        word[18:16] = bits[2:0];
        bits        = randBits(16);
        word[15:0]  = bits[15:0];
        return word;
    endfunction

    // Opcode 00 is a command, 01 data, 10 a fill of count plus one and 11 control
    function automatic void addExpected(input hostPkg::hostWord_t word);
        logic [1:0] op;
        int         runLength;
        op        = word[31:30];
        runLength = (op == 2'b10) ? int'(word[29:16]) + 1 : 1;
        if (op == 2'b11) begin
            expQ.push_back({1'b1, 1'b0, 14'd0, word[1:0]});
            finalCtrl = word[1:0];
        end else begin
            for (int i = 0; i < runLength; i++) begin
                expQ.push_back({1'b0, op != 2'b00, word[15:0]});
                pendingWrites++;
            end
        end
    endfunction

    task automatic endRun();
        $display("Summary: %0d tests, %0d writes checked, %0d errors", testsDone,
                 writesChecked, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic sendWord(input hostPkg::hostWord_t word);
        int waited;
        waited = 0;
        while (hostCredits == 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TimeoutCycles) begin
                $display("Timeout: no word credit came back from the DUT");
                errors++;
                endRun();
            end
        end
        addExpected(word);
        wordValid = 1'b1;
        wordData  = word;
        @(posedge clk);
        #1;
        wordValid = 1'b0;
    endtask

    // Idle means all writes seen, cs high and the final levels on the pins
    task automatic drain(input string name);
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < QuietCycles) begin
            @(posedge clk);
            #1;
            if (pendingWrites == 0 && lcdCs && {lcdRst, lcdBacklight} == finalCtrl) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            waited++;
            if (waited > TimeoutCycles) begin
                $display("Timeout: %s did not drain, %0d writes missing, %0d credits",
                         name, pendingWrites, hostCredits);
                errors++;
                endRun();
            end
        end
        creditsBack: assert (hostCredits == WordDepth) else begin
            $display("FAIL %0t: host credits %0d after idle", $time, hostCredits);
            errors++;
        end
        expQ.delete();
        testsDone++;
        $display("Test %s finished, errors so far %0d", name, errors);
    endtask

    //----------------------------------------
    // Test sequence
    //----------------------------------------
    initial begin
        logic [31:0] gap;
        clk           = 1'b0;
        RSTn          = 1'b1;
        wordValid     = 1'b0;
        wordData      = '0;
        lfsr          = 32'd83113;
        finalCtrl     = 2'b00;
        pendingWrites = 0;
        errors        = 0;
        writesChecked = 0;
        testsDone     = 0;
        #5 RSTn = 1'b0;
        repeat (3) @(posedge clk);
        #1 RSTn = 1'b1;

        resetRelease: assert (lcdCs && lcdWr && lcdRd && !lcdRst && !lcdBacklight &&
                              lcdData == '0 && !wordCredit) else begin
            $display("FAIL %0t: outputs not in reset state after reset", $time);
            errors++;
        end
        testsDone++;
        $display("Test reset finished, errors so far %0d", errors);

        sendWord(32'h0000_002A);
        sendWord(32'h4000_1234);
        sendWord(32'h0000_002C);
        sendWord(32'h4000_ABCD);
        drain("command and data");

        sendWord(32'h4000_0F0F);
        sendWord(32'h8005_F800);
        sendWord(32'h0000_002C);
        sendWord(32'h8000_07E0);
        drain("fill");

        sendWord(32'h4000_1111);
        sendWord(32'hC000_0003);
        sendWord(32'h4000_2222);
        sendWord(32'h8002_3333);
        sendWord(32'hC000_0002);
        sendWord(32'hC000_0001);
        sendWord(32'h0000_0029);
        drain("control order");

        for (int i = 0; i < 80; i++) begin
            sendWord(randomWord());
            gap = randBits(1);
            if (gap[0]) begin
                @(posedge clk);
                #1;
            end
        end
        drain("random stream");

        endRun();
    end

endmodule

// File: compile.f
hw/hostPkg.sv
hw/lcdPkg.sv
hw/lcdBus.sv
hw/creditFifo.sv
hw/wordDecoder.sv
hw/lcdWriter.sv
hw/lcdPanelTop.sv
sim/tbLcdPanel.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tbLcdPanel -f compile.f -o simLcdPanel

output=$(./obj_dir/simLcdPanel)
echo "$output"

# Pass only when the testbench printed the pass message
echo "$output" | grep -q "Test completed successfully"
